//--- verilog/ahb_config.svh
`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// htrans codes.
`define TRN_IDLE   2'b00
`define TRN_NONSEQ 2'b10
`define TRN_SEQ    2'b11

// hsize code for a full word.
`define SIZ_32BIT  3'b010

// hburst codes.
`define BUR_SINGLE 3'b000
`define BUR_INCR16 3'b111

`define LINE_WORDS 16               // beats per cache line.
`define LINE_MASK  32'hffff_ffc0    // 64 byte line base.

`define MEM_WORDS  1024             // sram depth in words.

`endif

//--- verilog/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  beat_t;    // beat within a line.
	typedef logic [1:0]  trans_t;

	typedef struct packed {
		logic       busreq;
		logic       lock;
		trans_t     trans;
		logic       write;
		logic [2:0] size;
		logic [2:0] burst;
		addr_t      addr;
		word_t      wdata;       // data phase, one cycle behind addr.
	} ahb_req_t;

	typedef struct packed {
		logic       ready;
		logic [1:0] resp;
		word_t      rdata;
	} ahb_rsp_t;

	typedef struct packed {
		logic  start;            // single cycle pulse.
		logic  write;
		addr_t addr;
		word_t wdata;
	} client_req_t;

	typedef struct packed {
		logic  beat_valid;
		logic  done;
		logic  busy;
		word_t rdata;
	} client_rsp_t;

	typedef enum logic [2:0] {
		idle,
		wait_grant,
		read_addr,
		read_seq,
		read_last,
		write_addr,
		write_data
	} master_state_t;

endpackage

`default_nettype wire

//--- verilog/ahb_line_master.sv
`timescale 1ns/100ps
`default_nettype none
`include "ahb_config.svh"

module ahb_line_master (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                hgrant,
	input  wire ahb_pkg::ahb_rsp_t   bus_rsp,
	input  wire ahb_pkg::client_req_t client_req,
	output ahb_pkg::client_rsp_t     client_rsp,
	output ahb_pkg::ahb_req_t        bus_req
);

	import ahb_pkg::*;

	master_state_t state;
	master_state_t next_state;
	beat_t         beat;
	addr_t         base;
	word_t         wdata_q;
	logic          write_q;
	logic          accept;
	logic          requesting;

	assign accept = (state == idle) && client_req.start;  // ignored while busy.

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= idle;
			beat    <= '0;
			write_q <= 1'b0;
		end else begin
			state <= next_state;
			if (accept)
				write_q <= client_req.write;
			if ((state == read_addr || state == read_seq) && bus_rsp.ready)
				beat <= beat + 1'b1;  // wraps to zero after the last beat.
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			base    <= client_req.write ? client_req.addr : (client_req.addr & `LINE_MASK);
			wdata_q <= client_req.wdata;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (client_req.start)
					next_state = wait_grant;
			end
			wait_grant: begin
				if (hgrant && bus_rsp.ready)
					next_state = write_q ? write_addr : read_addr;
			end
			read_addr: begin
				if (bus_rsp.ready)
					next_state = read_seq;
			end
			read_seq: begin
				if (bus_rsp.ready && beat == beat_t'(`LINE_WORDS - 1))
					next_state = read_last;
			end
			read_last: begin
				if (bus_rsp.ready)
					next_state = idle;
			end
			write_addr: begin
				if (bus_rsp.ready)
					next_state = write_data;
			end
			write_data: begin
				if (bus_rsp.ready)
					next_state = idle;
			end
			default: next_state = idle;
		endcase
	end

	assign requesting = (state == wait_grant) || (state == read_addr) ||
		(state == read_seq) || (state == write_addr);

	always_comb begin
		bus_req        = '0;
		bus_req.trans  = `TRN_IDLE;
		bus_req.busreq = requesting;
		bus_req.lock   = requesting && !write_q;  // reads keep the bus for the line.
		case (state)
			read_addr, read_seq: begin
				bus_req.trans = (state == read_addr) ? `TRN_NONSEQ : `TRN_SEQ;
				bus_req.size  = `SIZ_32BIT;
				bus_req.burst = `BUR_INCR16;
				bus_req.addr  = base + {26'd0, beat, 2'b00};
			end
			write_addr: begin
				bus_req.trans = `TRN_NONSEQ;
				bus_req.write = 1'b1;
				bus_req.size  = `SIZ_32BIT;
				bus_req.burst = `BUR_SINGLE;
				bus_req.addr  = base;
			end
			write_data: begin
				bus_req.wdata = wdata_q;
			end
			default: begin
				bus_req.trans = `TRN_IDLE;
			end
		endcase
	end

	// read data phases complete in read_seq and read_last.
	always_comb begin
		client_rsp.beat_valid = bus_rsp.ready && (state == read_seq || state == read_last);
		client_rsp.done       = bus_rsp.ready && (state == read_last || state == write_data);
		client_rsp.busy       = (state != idle);
		client_rsp.rdata      = bus_rsp.rdata;
	end

endmodule

`default_nettype wire

//--- verilog/ahb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "ahb_config.svh"

module ahb_arbiter (
	input  wire logic             clock,
	input  wire logic             reset,
	input  wire ahb_pkg::ahb_req_t m0_req,
	input  wire ahb_pkg::ahb_req_t m1_req,
	input  wire logic             ready,
	output logic                  m0_grant,
	output logic                  m1_grant,
	output ahb_pkg::ahb_req_t     slave_req
);

	import ahb_pkg::*;

	logic     owner;        // address phase owner.
	logic     data_owner;   // data phase owner.
	ahb_req_t own_req;
	ahb_req_t other_req;
	logic     release_bus;

	assign own_req   = owner ? m1_req : m0_req;
	assign other_req = owner ? m0_req : m1_req;

	assign m0_grant = !owner;
	assign m1_grant = owner;

	// owner idle and unlocked, so the other master takes its turn.
	assign release_bus = ready && !own_req.busreq && !own_req.lock;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner      <= 1'b0;  // master 0 is the default master.
			data_owner <= 1'b0;
		end else begin
			if (ready && own_req.trans != `TRN_IDLE)
				data_owner <= owner;
			if (release_bus && other_req.busreq)
				owner <= !owner;
		end
	end

	always_comb begin
		slave_req       = own_req;
		slave_req.wdata = data_owner ? m1_req.wdata : m0_req.wdata;
	end

endmodule

`default_nettype wire

//--- verilog/ahb_sram.sv
`timescale 1ns/100ps
`default_nettype none
`include "ahb_config.svh"

module ahb_sram (
	input  wire logic             clock,
	input  wire logic             reset,
	input  wire ahb_pkg::ahb_req_t bus_req,
	output ahb_pkg::ahb_rsp_t     bus_rsp
);

	import ahb_pkg::*;

	localparam int IDX_W = $clog2(`MEM_WORDS);

	word_t            mem [`MEM_WORDS] = '{default: '0};
	logic             ready_q;
	logic             dp_valid;
	logic             dp_write;
	logic [IDX_W-1:0] dp_index;
	logic             accept;

	assign accept = ready_q && (bus_req.trans != `TRN_IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			ready_q  <= 1'b1;
			dp_valid <= 1'b0;
		end else begin
			ready_q <= !(accept && bus_req.trans == `TRN_NONSEQ);  // one wait per nonseq.
			if (ready_q)
				dp_valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			dp_write <= bus_req.write;
			dp_index <= bus_req.addr[IDX_W+1:2];
		end
		if (ready_q && dp_valid && dp_write)
			mem[dp_index] <= bus_req.wdata;
	end

	assign bus_rsp = '{
		ready: ready_q,
		resp:  2'b00,          // okay.
		rdata: mem[dp_index]
	};

endmodule

`default_nettype wire

//--- verilog/ahb_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_subsystem (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire ahb_pkg::client_req_t client0_req,
	input  wire ahb_pkg::client_req_t client1_req,
	output ahb_pkg::client_rsp_t     client0_rsp,
	output ahb_pkg::client_rsp_t     client1_rsp
);

	import ahb_pkg::*;

	ahb_req_t m0_bus_req;
	ahb_req_t m1_bus_req;
	ahb_req_t slave_req;
	ahb_rsp_t bus_rsp;      // shared by both masters.
	logic     m0_grant;
	logic     m1_grant;

	ahb_line_master u_master0 (
		.clock      (clock),
		.reset      (reset),
		.hgrant     (m0_grant),
		.bus_rsp    (bus_rsp),
		.client_req (client0_req),
		.client_rsp (client0_rsp),
		.bus_req    (m0_bus_req)
	);

	ahb_line_master u_master1 (
		.clock      (clock),
		.reset      (reset),
		.hgrant     (m1_grant),
		.bus_rsp    (bus_rsp),
		.client_req (client1_req),
		.client_rsp (client1_rsp),
		.bus_req    (m1_bus_req)
	);

	ahb_arbiter u_arbiter (
		.clock     (clock),
		.reset     (reset),
		.m0_req    (m0_bus_req),
		.m1_req    (m1_bus_req),
		.ready     (bus_rsp.ready),
		.m0_grant  (m0_grant),
		.m1_grant  (m1_grant),
		.slave_req (slave_req)
	);

	ahb_sram u_sram (
		.clock   (clock),
		.reset   (reset),
		.bus_req (slave_req),
		.bus_rsp (bus_rsp)
	);

endmodule

`default_nettype wire

//--- bench/ahb_subsystem_asserts.sv
`timescale 1ns/100ps
`default_nettype none
`include "ahb_config.svh"

module ahb_subsystem_asserts (
	input wire logic              clock,
	input wire logic              reset,
	input wire logic              m0_grant,
	input wire logic              m1_grant,
	input wire ahb_pkg::ahb_req_t m0_bus_req,
	input wire ahb_pkg::ahb_req_t m1_bus_req,
	input wire ahb_pkg::ahb_req_t slave_req,
	input wire ahb_pkg::ahb_rsp_t bus_rsp
);

	import ahb_pkg::*;

	int unsigned failures = 0;  // failed assertions so far.
	logic [3:0]  seq_left;      // seq beats still owed by the burst.
	addr_t       seq_addr;
	logic        accepted;

	assign accepted = bus_rsp.ready && (slave_req.trans != `TRN_IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			seq_left <= '0;
		end else if (accepted && slave_req.trans == `TRN_NONSEQ &&
			slave_req.burst == `BUR_INCR16) begin
			seq_left <= 4'd15;
			seq_addr <= slave_req.addr + 32'd4;
		end else if (accepted && slave_req.trans == `TRN_SEQ) begin
			seq_left <= seq_left - 4'd1;
			seq_addr <= seq_addr + 32'd4;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		(m0_bus_req.trans == `TRN_IDLE || m0_grant) &&
		(m1_bus_req.trans == `TRN_IDLE || m1_grant)) else begin
		$error("a master drives a transfer without its grant");
		failures++;
	end

	assert property (@(posedge clock) disable iff (reset)
		slave_req.lock |=> $stable(m0_grant)) else begin
		$error("bus owner changed while lock was high");
		failures++;
	end

	assert property (@(posedge clock) disable iff (reset)
		((seq_left != 0) == (slave_req.trans == `TRN_SEQ)) &&
		(slave_req.trans != `TRN_SEQ || slave_req.addr == seq_addr)) else begin
		$error("incr16 burst does not carry 15 seq beats rising by 4");
		failures++;
	end

	assert property (@(posedge clock) reset |=> slave_req.trans == `TRN_IDLE) else begin
		$error("bus not idle after reset");
		failures++;
	end

endmodule

bind ahb_subsystem ahb_subsystem_asserts u_asserts (
	.clock      (clock),
	.reset      (reset),
	.m0_grant   (m0_grant),
	.m1_grant   (m1_grant),
	.m0_bus_req (m0_bus_req),
	.m1_bus_req (m1_bus_req),
	.slave_req  (slave_req),
	.bus_rsp    (bus_rsp)
);

`default_nettype wire

//--- bench/tb_ahb_subsystem.sv
`timescale 1ns/100ps
`default_nettype none
`include "ahb_config.svh"

module tb_ahb_subsystem;

	import ahb_pkg::*;

	localparam int RANDOM_CYCLES  = 300;
	localparam int TIMEOUT_CYCLES = 40 * 40 + 400;  // 40 ops of up to 40 cycles.

	logic        clock = 1'b0;
	logic        reset = 1'b1;
	client_req_t req [2] = '{default: '0};
	client_rsp_t rsp [2];
	word_t       model [`MEM_WORDS] = '{default: '0};
	logic [31:0] lfsr = 32'hfd6f_6781;
	int          errors = 0;
	int          cycles = 0;
	logic        started = 1'b0;
	logic        pending [2] = '{1'b0, 1'b0};
	logic        act_write [2];
	addr_t       act_base [2];
	word_t       act_wdata [2];
	int          beats [2];

	ahb_subsystem u_dut (
		.clock       (clock),
		.reset       (reset),
		.client0_req (req[0]),
		.client1_req (req[1]),
		.client0_rsp (rsp[0]),
		.client1_rsp (rsp[1])
	);

	initial begin
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic int line_word(input addr_t base, input int beat);
		return (int'(base[11:2]) + beat) % `MEM_WORDS;
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_text(input string text);
		$display("Error at %0t ns: %s", $time, text);
		errors++;
	endtask

	task automatic random_start(input int c);
		logic [31:0] bits;
		logic        write;
		addr_t       addr;
		take_bits(1, bits);
		write = bits[0];
		take_bits(12, addr);  // stays inside the sram.
		take_bits(32, bits);
		req[c] = '{1'b1, write, addr, bits};
	endtask

	task automatic finish_ops();
		@(negedge clock);
		req[0].start = 1'b0;
		req[1].start = 1'b0;
		do
			@(negedge clock);
		while (rsp[0].busy || rsp[1].busy);
	endtask

	// nothing may move on the client ports before the first start.
	assert property (@(posedge clock) disable iff (reset)
		!started |-> !(rsp[0].busy || rsp[0].done || rsp[1].busy || rsp[1].done))
		else report_value("client busy/done", 32'd0,
			{28'd0, rsp[1].busy, rsp[1].done, rsp[0].busy, rsp[0].done});

	always @(posedge clock) begin
		client_rsp_t r;
		string       name;
		logic        was_pending;
		if (!reset) begin
			for (int c = 0; c < 2; c++) begin
				r           = rsp[c];
				name        = $sformatf("client%0d_rsp", c);
				was_pending = pending[c];
				assert (r.busy == was_pending)
					else report_value({name, ".busy"}, {31'd0, was_pending}, {31'd0, r.busy});
				assert (r.beat_valid || !pending[c] || act_write[c] || beats[c] == 0)
					else report_text($sformatf("%s read beats are not contiguous", name));
				if (r.beat_valid) begin
					assert (pending[c] && !act_write[c])
						else report_text($sformatf("%s gave a beat with no read", name));
					assert (r.rdata == model[line_word(act_base[c], beats[c])])
						else report_value({name, ".rdata"},
							model[line_word(act_base[c], beats[c])], r.rdata);
					beats[c]++;
				end
				if (r.done) begin
					assert (pending[c])
						else report_text($sformatf("%s done with no accepted start", name));
					if (act_write[c]) begin
						model[act_base[c][11:2]] = act_wdata[c];
					end else begin
						assert (beats[c] == `LINE_WORDS)
							else report_value({name, ".beat_valid count"}, `LINE_WORDS, beats[c]);
					end
					pending[c] = 1'b0;
				end
				if (req[c].start && !was_pending) begin  // accepted start.
					pending[c]   = 1'b1;
					act_write[c] = req[c].write;
					act_base[c]  = req[c].write ? req[c].addr : {req[c].addr[31:6], 6'd0};
					act_wdata[c] = req[c].wdata;
					beats[c]     = 0;
					started      = 1'b1;
				end
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		addr_t a;
		word_t d;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		repeat (5) @(negedge clock);
		take_bits(12, a);
		take_bits(32, d);
		req[0] = '{1'b1, 1'b1, a, d};  // write, then read its line back.
		finish_ops();
		req[0] = '{1'b1, 1'b0, a, '0};
		finish_ops();
		take_bits(12, a);
		req[0] = '{1'b1, 1'b0, a | 32'h4, '0};  // unaligned line read.
		finish_ops();
		take_bits(12, a);
		req[0] = '{1'b1, 1'b0, a, '0};
		take_bits(12, a);
		req[1] = '{1'b1, 1'b0, a, '0};  // both clients at once.
		finish_ops();
		repeat (RANDOM_CYCLES) begin
			for (int c = 0; c < 2; c++) begin
				take_bits(2, d);
				if (d[1:0] == 2'b00)
					random_start(c);
				else
					req[c].start = 1'b0;
			end
			@(negedge clock);
		end
		finish_ops();
		assert (!pending[0] && !pending[1])
			else report_text("a request ended without its done pulse");
		$display("errors: %0d testbench, %0d protocol", errors, u_dut.u_asserts.failures);
		if (errors == 0 && u_dut.u_asserts.failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/ahb_pkg.sv
verilog/ahb_line_master.sv
verilog/ahb_arbiter.sv
verilog/ahb_sram.sv
verilog/ahb_subsystem.sv
bench/ahb_subsystem_asserts.sv
bench/tb_ahb_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_subsystem \
	-f vlog.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
